//--- trap_pkg.sv
//==========================================================================
// Machine-mode trap definitions
// Exception and interrupt records, cause codes, arbitration priorities,
// CSR addresses and mstatus/mtvec field positions shared by the trap unit
//==========================================================================

`default_nettype none

package trap_pkg;

    //======================================================================
    // Widths and interrupt lines
    //======================================================================

    localparam int XLEN    = 32;
    localparam int NUM_IRQ = 3;
    localparam int CAUSE_W = 5;
    localparam int PRIO_W  = 4;

    // Line indices into irq_i, pending and request vectors
    localparam int IRQ_SW    = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    typedef logic [CAUSE_W-1:0] cause_t;
    typedef logic [PRIO_W-1:0]  prio_t;

    //======================================================================
    // Cause codes
    //======================================================================

    // Interrupt causes, also the mie/mip bit positions
    localparam cause_t CAUSE_M_SW    = 5'd3;
    localparam cause_t CAUSE_M_TIMER = 5'd7;
    localparam cause_t CAUSE_M_EXT   = 5'd11;

    // Synchronous exception causes
    localparam cause_t CAUSE_INSN_MISALIGNED  = 5'd0;
    localparam cause_t CAUSE_INSN_FAULT       = 5'd1;
    localparam cause_t CAUSE_ILLEGAL_INSN     = 5'd2;
    localparam cause_t CAUSE_BREAKPOINT       = 5'd3;
    localparam cause_t CAUSE_LOAD_MISALIGNED  = 5'd4;
    localparam cause_t CAUSE_LOAD_FAULT       = 5'd5;
    localparam cause_t CAUSE_STORE_MISALIGNED = 5'd6;
    localparam cause_t CAUSE_STORE_FAULT      = 5'd7;
    localparam cause_t CAUSE_ECALL_M          = 5'd11;

    // Line index to cause code, ordered by IRQ_SW, IRQ_TIMER, IRQ_EXT
    localparam cause_t IRQ_CAUSE [NUM_IRQ] = '{CAUSE_M_SW, CAUSE_M_TIMER, CAUSE_M_EXT};

    //======================================================================
    // Priorities, lower value wins
    //======================================================================

    localparam prio_t PRIO_IRQ          = 4'd0;
    localparam prio_t PRIO_BREAKPOINT   = 4'd1;
    localparam prio_t PRIO_INSN_FAULT   = 4'd2;
    localparam prio_t PRIO_ILLEGAL      = 4'd3;
    localparam prio_t PRIO_ECALL        = 4'd4;
    localparam prio_t PRIO_MISALIGNED   = 4'd5;
    localparam prio_t PRIO_ACCESS_FAULT = 4'd6;
    // Marks an empty slot
    localparam prio_t PRIO_NONE         = 4'd15;

    //======================================================================
    // Records
    //======================================================================

    typedef enum logic {
        EXC_TYPE_EXCEPTION = 1'b0,
        EXC_TYPE_INTERRUPT = 1'b1
    } exc_type_t;

    // 75 bits, one trap candidate or the selected trap
    typedef struct packed {
        logic             valid;
        exc_type_t        exc_type;
        cause_t           cause;
        prio_t            prio;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  tval;
    } exception_info_t;

    // 9 bits, masked interrupt state
    typedef struct packed {
        logic   m_software_interrupt;
        logic   m_timer_interrupt;
        logic   m_external_interrupt;
        logic   interrupt_pending;
        cause_t interrupt_cause;
    } interrupt_info_t;

    //======================================================================
    // CSR map
    //======================================================================

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MTVAL   = 12'h343;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

endpackage

`default_nettype wire

//--- irq_gate.sv
//==========================================================================
// Interrupt line gate
// Two-flop synchronizer for one asynchronous interrupt level, giving the
// mip pending bit and the request masked by mie and mstatus.MIE
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module irq_gate (
    input  wire logic clk_i,
    input  wire logic rst_i,
    // Raw asynchronous level
    input  wire logic irq_i,
    // Per-line enable from mie
    input  wire logic enable_i,
    // Global enable from mstatus.MIE
    input  wire logic global_en_i,
    output logic      pending_o,
    output logic      request_o
);

    // Stage 0 may go metastable, stage 1 is the clean copy
    logic [1:0] sync_q;

    //======================================================================
    // Synchronizer
    //======================================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], irq_i};
        end
    end

    // Pending after exactly two edges
    assign pending_o = sync_q[1];

    // Request needs both the line enable and the global enable
    assign request_o = sync_q[1] & enable_i & global_en_i;

endmodule

`default_nettype wire

//--- trap_csr.sv
//==========================================================================
// Machine trap CSRs
// Holds mstatus (MIE/MPIE), mie, mtvec, mepc, mcause and mtval, serves the
// software CSR port, records trap entry and unstacks MIE on mret
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module trap_csr
    import trap_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    // Software CSR port
    input  wire logic            csr_we_i,
    input  wire logic [11:0]     csr_addr_i,
    input  wire logic [XLEN-1:0] csr_wdata_i,
    output logic [XLEN-1:0]      csr_rdata_o,
    // Trap entry from the handler
    input  wire logic            trap_valid_i,
    input  exception_info_t      trap_info_i,
    // Trap return strobe
    input  wire logic            mret_i,
    // Synchronized lines shown as mip
    input  wire logic [NUM_IRQ-1:0] irq_pending_i,
    // Enables and vector setup for the gates and handler
    output logic                 mstatus_mie_o,
    output logic [NUM_IRQ-1:0]   mie_o,
    output logic [XLEN-1:0]      mtvec_base_o,
    output logic [1:0]           mtvec_mode_o
);

    logic               mstatus_mie_q;
    logic               mstatus_mpie_q;
    logic [NUM_IRQ-1:0] mie_q;
    // Bit 1 always held at zero so only direct and vectored modes exist
    logic [XLEN-1:0]    mtvec_q;
    logic [XLEN-1:0]    mepc_q;
    logic [XLEN-1:0]    mcause_q;
    logic [XLEN-1:0]    mtval_q;
    logic [XLEN-1:0]    trap_mcause;

    // Interrupt flag in bit 31, cause code in the low bits
    assign trap_mcause = {trap_info_i.exc_type == EXC_TYPE_INTERRUPT,
                          {(XLEN-1-CAUSE_W){1'b0}},
                          trap_info_i.cause};

    //======================================================================
    // CSR state
    //======================================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end else begin
            // Software writes first, trap and mret below override them
            if (csr_we_i) begin
                case (csr_addr_i)
                    CSR_MSTATUS: begin
                        mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
                        mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
                    end
                    CSR_MIE: begin
                        for (int i = 0; i < NUM_IRQ; i++) begin
                            mie_q[i] <= csr_wdata_i[IRQ_CAUSE[i]];
                        end
                    end
                    CSR_MTVEC: mtvec_q  <= {csr_wdata_i[XLEN-1:2], 1'b0, csr_wdata_i[0]};
                    CSR_MEPC:   mepc_q   <= csr_wdata_i;
                    CSR_MCAUSE: mcause_q <= csr_wdata_i;
                    CSR_MTVAL:  mtval_q  <= csr_wdata_i;
                    default: ;
                endcase
            end

            if (trap_valid_i) begin
                // Trap entry, stack MIE and disable interrupts
                mepc_q         <= trap_info_i.pc;
                mcause_q       <= trap_mcause;
                mtval_q        <= trap_info_i.tval;
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
            end else if (mret_i) begin
                // Trap return, unstack MIE
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end
        end
    end

    //======================================================================
    // Read port
    //======================================================================

    always_comb begin
        csr_rdata_o = '0;
        case (csr_addr_i)
            CSR_MSTATUS: begin
                csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
                csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
            end
            CSR_MIE: begin
                for (int i = 0; i < NUM_IRQ; i++) begin
                    csr_rdata_o[IRQ_CAUSE[i]] = mie_q[i];
                end
            end
            // mip is read-only, straight from the synchronizers
            CSR_MIP: begin
                for (int i = 0; i < NUM_IRQ; i++) begin
                    csr_rdata_o[IRQ_CAUSE[i]] = irq_pending_i[i];
                end
            end
            CSR_MTVEC:  csr_rdata_o = mtvec_q;
            CSR_MEPC:   csr_rdata_o = mepc_q;
            CSR_MCAUSE: csr_rdata_o = mcause_q;
            CSR_MTVAL:  csr_rdata_o = mtval_q;
            // Unmapped addresses read zero
            default:    csr_rdata_o = '0;
        endcase
    end

    // Outputs to gates and handler
    assign mstatus_mie_o = mstatus_mie_q;
    assign mie_o         = mie_q;
    assign mtvec_base_o  = mtvec_q;
    assign mtvec_mode_o  = mtvec_q[1:0];

endmodule

`default_nettype wire

//--- exception_handler.sv
//==========================================================================
// Trap arbiter
// Picks one trap from the masked interrupt requests and the four stage
// exception reports, and computes its record and trap vector from mtvec
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module exception_handler
    import trap_pkg::*;
(
    // Stage exception reports
    input  exception_info_t         fetch_exc_i,
    input  exception_info_t         execute_exc_i,
    input  exception_info_t         memory_exc_i,
    input  exception_info_t         writeback_exc_i,
    // Masked requests from the gates
    input  wire logic [NUM_IRQ-1:0] irq_req_i,
    // Resume pc for an interrupt
    input  wire logic [XLEN-1:0]    irq_pc_i,
    // Trap vector setup
    input  wire logic [XLEN-1:0]    mtvec_base_i,
    input  wire logic [1:0]         mtvec_mode_i,
    output logic                    trap_valid_o,
    output exception_info_t         trap_info_o,
    output logic [XLEN-1:0]         trap_vector_o,
    output interrupt_info_t         interrupt_info_o
);

    exception_info_t stage_exc [4];
    exception_info_t irq_exc;
    exception_info_t best_exc;
    exception_info_t sel_exc;
    prio_t           best_prio;
    logic            best_found;
    cause_t          irq_cause;
    logic [XLEN-1:0] vec_base;

    //======================================================================
    // Interrupt selection
    //======================================================================

    // Later lines override earlier ones, so external beats timer beats software
    always_comb begin
        irq_cause = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (irq_req_i[i]) begin
                irq_cause = IRQ_CAUSE[i];
            end
        end
    end

    assign interrupt_info_o.m_software_interrupt = irq_req_i[IRQ_SW];
    assign interrupt_info_o.m_timer_interrupt    = irq_req_i[IRQ_TIMER];
    assign interrupt_info_o.m_external_interrupt = irq_req_i[IRQ_EXT];
    assign interrupt_info_o.interrupt_pending    = |irq_req_i;
    assign interrupt_info_o.interrupt_cause      = irq_cause;

    // Interrupt candidate, pc supplied by the core and no tval
    always_comb begin
        irq_exc          = '0;
        irq_exc.valid    = |irq_req_i;
        irq_exc.exc_type = EXC_TYPE_INTERRUPT;
        irq_exc.cause    = irq_cause;
        irq_exc.prio     = PRIO_IRQ;
        irq_exc.pc       = irq_pc_i;
    end

    //======================================================================
    // Stage exception selection
    //======================================================================

    // Slot order sets the tie break, fetch first
    assign stage_exc[0] = fetch_exc_i;
    assign stage_exc[1] = execute_exc_i;
    assign stage_exc[2] = memory_exc_i;
    assign stage_exc[3] = writeback_exc_i;

    // Strict less-than keeps the earliest slot on a tie
    always_comb begin
        best_exc   = '0;
        best_prio  = PRIO_NONE;
        best_found = 1'b0;
        for (int s = 0; s < 4; s++) begin
            if (stage_exc[s].valid && (!best_found || stage_exc[s].prio < best_prio)) begin
                best_exc   = stage_exc[s];
                best_prio  = stage_exc[s].prio;
                best_found = 1'b1;
            end
        end
    end

    // Any requested interrupt wins over stage exceptions
    assign sel_exc = irq_exc.valid ? irq_exc : best_exc;

    //======================================================================
    // Trap vector
    //======================================================================

    assign vec_base = {mtvec_base_i[XLEN-1:2], 2'b00};

    always_comb begin
        trap_vector_o = '0;
        if (sel_exc.valid) begin
            // Only interrupts are vectored, exceptions go to the base
            if (sel_exc.exc_type == EXC_TYPE_INTERRUPT && mtvec_mode_i == MTVEC_VECTORED) begin
                trap_vector_o = vec_base + (XLEN'(sel_exc.cause) << 2);
            end else begin
                trap_vector_o = vec_base;
            end
        end
    end

    // Selected record doubles as the flush request
    assign trap_valid_o = sel_exc.valid;
    assign trap_info_o  = sel_exc;

endmodule

`default_nettype wire

//--- trap_unit_top.sv
//==========================================================================
// Machine-mode trap unit
// CSR block, three interrupt gates and the trap arbiter of an RV32 core
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module trap_unit_top
    import trap_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    // Stage exception levels
    input  exception_info_t         fetch_exc_i,
    input  exception_info_t         execute_exc_i,
    input  exception_info_t         memory_exc_i,
    input  exception_info_t         writeback_exc_i,
    // Asynchronous interrupt levels, indexed by IRQ_SW/IRQ_TIMER/IRQ_EXT
    input  wire logic [NUM_IRQ-1:0] irq_i,
    input  wire logic [XLEN-1:0]    irq_pc_i,
    input  wire logic               mret_i,
    // CSR port
    input  wire logic               csr_we_i,
    input  wire logic [11:0]        csr_addr_i,
    input  wire logic [XLEN-1:0]    csr_wdata_i,
    output logic [XLEN-1:0]         csr_rdata_o,
    // Trap outputs, trap_valid_o also flushes the pipeline
    output logic                    trap_valid_o,
    output exception_info_t         trap_info_o,
    output logic [XLEN-1:0]         trap_vector_o,
    output interrupt_info_t         interrupt_info_o
);

    logic               mstatus_mie;
    logic [NUM_IRQ-1:0] mie;
    logic [NUM_IRQ-1:0] irq_pending;
    logic [NUM_IRQ-1:0] irq_req;
    logic [XLEN-1:0]    mtvec_base;
    logic [1:0]         mtvec_mode;

    // CSR block, records the trap selected below
    trap_csr csr_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_we_i      (csr_we_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_rdata_o   (csr_rdata_o),
        .trap_valid_i  (trap_valid_o),
        .trap_info_i   (trap_info_o),
        .mret_i        (mret_i),
        .irq_pending_i (irq_pending),
        .mstatus_mie_o (mstatus_mie),
        .mie_o         (mie),
        .mtvec_base_o  (mtvec_base),
        .mtvec_mode_o  (mtvec_mode)
    );

    // One gate per interrupt line
    for (genvar g = 0; g < NUM_IRQ; g++) begin : gen_irq
        irq_gate gate_i (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .irq_i       (irq_i[g]),
            .enable_i    (mie[g]),
            .global_en_i (mstatus_mie),
            .pending_o   (irq_pending[g]),
            .request_o   (irq_req[g])
        );
    end

    // Arbiter and vector generation
    exception_handler handler_i (
        .fetch_exc_i      (fetch_exc_i),
        .execute_exc_i    (execute_exc_i),
        .memory_exc_i     (memory_exc_i),
        .writeback_exc_i  (writeback_exc_i),
        .irq_req_i        (irq_req),
        .irq_pc_i         (irq_pc_i),
        .mtvec_base_i     (mtvec_base),
        .mtvec_mode_i     (mtvec_mode),
        .trap_valid_o     (trap_valid_o),
        .trap_info_o      (trap_info_o),
        .trap_vector_o    (trap_vector_o),
        .interrupt_info_o (interrupt_info_o)
    );

endmodule

`default_nettype wire

//--- trap_unit_props.sv
//==========================================================================
// Trap arbiter properties
// Vector alignment, idle outputs and interrupt origin of the selected trap
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module trap_unit_props
    import trap_pkg::*;
(
    input wire logic               clk_i,
    input wire logic               trap_valid_i,
    input exception_info_t         trap_info_i,
    input wire logic [XLEN-1:0]    trap_vector_i,
    input wire logic [NUM_IRQ-1:0] irq_req_i
);

    // Handler entry points are word aligned
    vector_aligned: assert property (@(posedge clk_i) trap_vector_i[1:0] == 2'b00)
        else $error("Trap vector not word aligned");

    // Idle outputs stay zero
    idle_zero: assert property (@(posedge clk_i)
        !trap_valid_i |-> (trap_vector_i == '0 && trap_info_i == '0))
        else $error("Trap record or vector nonzero without a trap");

    // An interrupt trap needs a live request
    irq_has_request: assert property (@(posedge clk_i)
        (trap_valid_i && trap_info_i.exc_type == EXC_TYPE_INTERRUPT) |-> |irq_req_i)
        else $error("Interrupt trap without a request bit");

endmodule

`default_nettype wire

//--- tb_trap_unit.sv
//==========================================================================
// Trap unit testbench
// Table of stage exception rows plus random rows, then directed interrupt,
// mret, masking and CSR read-back sequences against a small MIE model
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_trap_unit
    import trap_pkg::*;
;

    // One stimulus row with its expected trap
    typedef struct packed {
        exception_info_t f;
        exception_info_t e;
        exception_info_t m;
        exception_info_t w;
        logic [31:0]     mtvec;
        logic            exp_valid;
        cause_t          exp_cause;
        logic [31:0]     exp_pc;
        logic [31:0]     exp_tval;
    } row_t;

    logic               clk;
    logic               rst_i;
    exception_info_t    fetch_exc, execute_exc, memory_exc, writeback_exc;
    logic [NUM_IRQ-1:0] irq;
    logic [XLEN-1:0]    irq_pc;
    logic               mret;
    logic               csr_we;
    logic [11:0]        csr_addr;
    logic [XLEN-1:0]    csr_wdata;
    logic [XLEN-1:0]    csr_rdata;
    logic               trap_valid;
    exception_info_t    trap_info;
    logic [XLEN-1:0]    trap_vector;
    interrupt_info_t    irq_info;

    row_t   rows [$];
    integer seed = 90785;
    // Reference copy of mstatus.MIE and MPIE
    logic   mie_m;
    logic   mpie_m;
    // Reference copy of the per-line mie bits, indexed like irq
    logic [NUM_IRQ-1:0] ien_m;

    trap_unit_top dut_i (
        .clk_i (clk), .rst_i (rst_i),
        .fetch_exc_i (fetch_exc), .execute_exc_i (execute_exc),
        .memory_exc_i (memory_exc), .writeback_exc_i (writeback_exc),
        .irq_i (irq), .irq_pc_i (irq_pc), .mret_i (mret),
        .csr_we_i (csr_we), .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata), .trap_valid_o (trap_valid), .trap_info_o (trap_info),
        .trap_vector_o (trap_vector), .interrupt_info_o (irq_info)
    );

    bind exception_handler trap_unit_props props_i (
        .clk_i         (tb_trap_unit.clk),
        .trap_valid_i  (trap_valid_o),
        .trap_info_i   (trap_info_o),
        .trap_vector_i (trap_vector_o),
        .irq_req_i     (irq_req_i)
    );

    always #2 clk = ~clk;

    //======================================================================
    // Reporting and reference helpers
    //======================================================================

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            fail_stop("Value check failed");
        end
    endtask

    function automatic exception_info_t exc(input logic v, input cause_t c, input prio_t p,
                                            input logic [31:0] pc, input logic [31:0] tval);
        exception_info_t x;
        x = '0;
        x.valid = v;
        x.exc_type = EXC_TYPE_EXCEPTION;
        x.cause = c;
        x.prio = p;
        x.pc = pc;
        x.tval = tval;
        return x;
    endfunction

    // Smallest priority wins, earlier stage keeps a tie
    function automatic exception_info_t pick_stage(input exception_info_t f, e, m, w);
        exception_info_t s [4];
        exception_info_t win;
        s[0] = f;
        s[1] = e;
        s[2] = m;
        s[3] = w;
        win = '0;
        for (int i = 0; i < 4; i++) begin
            if (s[i].valid && (!win.valid || s[i].prio < win.prio)) win = s[i];
        end
        return win;
    endfunction

    // Base with low bits cleared, plus 4*cause only for vectored interrupts
    function automatic logic [31:0] vec_expected(input logic [31:0] mtvec, input logic is_irq,
                                                 input cause_t c);
        logic [31:0] base;
        base = {mtvec[31:2], 2'b00};
        if (is_irq && mtvec[1:0] == 2'd1) return base + {25'd0, c, 2'b00};
        return base;
    endfunction

    function automatic logic [31:0] mstatus_expected();
        return {24'd0, mpie_m, 3'd0, mie_m, 3'd0};
    endfunction

    //======================================================================
    // Bus tasks, all driving on the falling edge
    //======================================================================

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        csr_we = 1'b1;
        csr_addr = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
        // Line enables sit at mie bits 3, 7 and 11
        if (addr == CSR_MIE) begin
            ien_m = {data[CAUSE_M_EXT], data[CAUSE_M_TIMER], data[CAUSE_M_SW]};
        end
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp, input string name);
        @(negedge clk);
        csr_addr = addr;
        #1;
        check_val(name, csr_rdata, exp);
    endtask

    task automatic pulse_mret();
        @(negedge clk);
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        mie_m = mpie_m;
        mpie_m = 1'b1;
    endtask

    // Polls at falling edges until trap_valid rises
    task automatic wait_trap(input int limit);
        int n;
        n = 0;
        while (!trap_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (trap_valid) else fail_stop("No trap was raised before the timeout");
    endtask

    // Idle cycles also leave the interrupt summary empty
    task automatic no_trap_cycles(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_val("trap_valid_o", 32'(trap_valid), 32'd0);
            check_val("interrupt_info_o", 32'(irq_info), 32'd0);
        end
    endtask

    task automatic check_irq_trap(input cause_t c, input logic [31:0] mtvec, input int limit);
        logic [NUM_IRQ-1:0] req;
        wait_trap(limit);
        // Masked requests from the model, lines gated by mie and MIE
        req = irq & ien_m & {NUM_IRQ{mie_m}};
        check_val("trap cause", 32'(trap_info.cause), 32'(c));
        check_val("trap type", 32'(trap_info.exc_type), 32'(EXC_TYPE_INTERRUPT));
        check_val("trap_vector_o", trap_vector, vec_expected(mtvec, 1'b1, c));
        check_val("trap pc", trap_info.pc, irq_pc);
        check_val("interrupt_info_o", 32'(irq_info),
                  32'({req[IRQ_SW], req[IRQ_TIMER], req[IRQ_EXT], |req, c}));
        mpie_m = mie_m;
        mie_m = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        fetch_exc = r.f;
        execute_exc = r.e;
        memory_exc = r.m;
        writeback_exc = r.w;
        csr_we = 1'b1;
        csr_addr = CSR_MTVEC;
        csr_wdata = r.mtvec;
        @(negedge clk);
        csr_we = 1'b0;
        check_val("trap_valid_o", 32'(trap_valid), 32'(r.exp_valid));
        check_val("trap_vector_o", trap_vector,
                  r.exp_valid ? vec_expected(r.mtvec, 1'b0, r.exp_cause) : 32'd0);
        if (r.exp_valid) begin
            check_val("trap cause", 32'(trap_info.cause), 32'(r.exp_cause));
            check_val("trap type", 32'(trap_info.exc_type), 32'(EXC_TYPE_EXCEPTION));
            check_val("trap pc", trap_info.pc, r.exp_pc);
            check_val("trap tval", trap_info.tval, r.exp_tval);
        end
        @(negedge clk);
        fetch_exc = '0;
        execute_exc = '0;
        memory_exc = '0;
        writeback_exc = '0;
        if (r.exp_valid) begin
            // MIE is already clear, so the stacking keeps both bits low
            mpie_m = mie_m;
            mie_m = 1'b0;
            read_check(CSR_MEPC, r.exp_pc, "mepc");
            read_check(CSR_MCAUSE, 32'(r.exp_cause), "mcause");
            read_check(CSR_MTVAL, r.exp_tval, "mtval");
            read_check(CSR_MSTATUS, mstatus_expected(), "mstatus");
        end
    endtask

    function automatic row_t make_row(input exception_info_t f, e, m, w, input logic [31:0] mtvec);
        row_t r;
        exception_info_t win;
        win = pick_stage(f, e, m, w);
        r = '0;
        r.f = f;
        r.e = e;
        r.m = m;
        r.w = w;
        r.mtvec = mtvec;
        r.exp_valid = win.valid;
        r.exp_cause = win.cause;
        r.exp_pc = win.pc;
        r.exp_tval = win.tval;
        return r;
    endfunction

    function automatic exception_info_t random_exc();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] tval;
        r = $random(seed);
        pc = $random(seed);
        tval = $random(seed);
        return exc(r[0], r[8:4], {1'b0, r[3:1]}, pc, tval);
    endfunction

    // Hang guard on top of the per-wait timeouts
    initial begin
        #200000;
        fail_stop("Simulation watchdog expired");
    end

    //======================================================================
    // Main sequence
    //======================================================================

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        fetch_exc = '0;
        execute_exc = '0;
        memory_exc = '0;
        writeback_exc = '0;
        irq = '0;
        irq_pc = 32'h0000_4A40;
        mret = 1'b0;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        mie_m = 1'b0;
        mpie_m = 1'b0;
        ien_m = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // Reset state
        check_val("trap_valid_o", 32'(trap_valid), 32'd0);
        read_check(CSR_MSTATUS, 32'd0, "mstatus");
        read_check(CSR_MIE, 32'd0, "mie");
        read_check(CSR_MIP, 32'd0, "mip");
        read_check(CSR_MTVEC, 32'd0, "mtvec");
        read_check(CSR_MEPC, 32'd0, "mepc");
        read_check(CSR_MCAUSE, 32'd0, "mcause");
        read_check(CSR_MTVAL, 32'd0, "mtval");

        // Directed arbitration rows, expected winner written out by hand
        rows.push_back('{exc(1, CAUSE_ILLEGAL_INSN, 3, 32'h100, 32'hA), exc(1, CAUSE_LOAD_FAULT,
            3, 32'h104, 32'hB), '0, '0, 32'h2000, 1'b1, CAUSE_ILLEGAL_INSN, 32'h100, 32'hA});
        rows.push_back('{'0, exc(1, CAUSE_LOAD_FAULT, 6, 32'h200, 32'h11), exc(1,
            CAUSE_INSN_FAULT, 2, 32'h204, 32'h22), '0, 32'h2001, 1'b1, CAUSE_INSN_FAULT,
            32'h204, 32'h22});
        rows.push_back('{'0, '0, '0, exc(1, CAUSE_ECALL_M, 4, 32'h300, 32'h0), 32'h3001, 1'b1,
            CAUSE_ECALL_M, 32'h300, 32'h0});
        rows.push_back('{'0, '0, '0, '0, 32'h3000, 1'b0, 5'd0, 32'h0, 32'h0});
        rows.push_back('{'0, '0, exc(1, CAUSE_LOAD_MISALIGNED, 5, 32'h408, 32'h33),
            exc(1, CAUSE_STORE_MISALIGNED, 5, 32'h40C, 32'h44), 32'h4001, 1'b1,
            CAUSE_LOAD_MISALIGNED, 32'h408, 32'h33});
        // Random rows, expectation from the reference pick
        for (int k = 0; k < 12; k++) begin
            rows.push_back(make_row(random_exc(), random_exc(), random_exc(), random_exc(),
                                    $random(seed)));
        end
        for (int k = 0; k < rows.size(); k++) apply_row(rows[k]);

        // Masked by MIE, line still shows in mip
        csr_write(CSR_MTVEC, 32'h0001_0001);
        csr_write(CSR_MIE, 32'h0000_0888);
        @(negedge clk);
        irq = 3'b100;
        no_trap_cycles(4);
        read_check(CSR_MIP, 32'h0000_0800, "mip");

        // Enable MIE, external interrupt beats a fetch fault in the same cycle
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        mie_m = 1'b1;
        fetch_exc = exc(1, CAUSE_BREAKPOINT, 1, 32'h500, 32'h55);
        check_irq_trap(CAUSE_M_EXT, 32'h0001_0001, 2);
        @(negedge clk);
        check_val("trap cause", 32'(trap_info.cause), 32'(CAUSE_BREAKPOINT));
        fetch_exc = '0;
        read_check(CSR_MSTATUS, mstatus_expected(), "mstatus");
        read_check(CSR_MCAUSE, 32'h8000_000B, "mcause");
        read_check(CSR_MEPC, irq_pc, "mepc");
        read_check(CSR_MTVAL, 32'd0, "mtval");
        no_trap_cycles(2);

        // Timer beats software after mret
        irq = 3'b011;
        no_trap_cycles(3);
        pulse_mret();
        check_irq_trap(CAUSE_M_TIMER, 32'h0001_0001, 2);
        @(negedge clk);
        check_val("trap_valid_o", 32'(trap_valid), 32'd0);
        irq = 3'b001;
        no_trap_cycles(3);
        pulse_mret();
        check_irq_trap(CAUSE_M_SW, 32'h0001_0001, 2);
        read_check(CSR_MCAUSE, 32'h8000_0003, "mcause");

        // Nothing pending, mret just reopens MIE
        irq = 3'b000;
        no_trap_cycles(3);
        pulse_mret();
        no_trap_cycles(3);
        read_check(CSR_MSTATUS, mstatus_expected(), "mstatus");

        // Line mie bit clear blocks its request
        csr_write(CSR_MIE, 32'h0000_0080);
        irq = 3'b001;
        no_trap_cycles(4);
        read_check(CSR_MIP, 32'h0000_0008, "mip");
        read_check(CSR_MIE, 32'h0000_0080, "mie");
        read_check(12'h7C0, 32'd0, "unknown csr");

        // Fully enabled timer line traps on the second edge after it rises
        @(negedge clk);
        irq = 3'b011;
        no_trap_cycles(1);
        check_irq_trap(CAUSE_M_TIMER, 32'h0001_0001, 1);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
trap_pkg.sv
irq_gate.sv
trap_csr.sv
exception_handler.sv
trap_unit_top.sv
trap_unit_props.sv
tb_trap_unit.sv

//--- Makefile
# Verilator build for the trap unit testbench
VERILATOR ?= verilator
TOP       ?= tb_trap_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
